//--- source/mac_rx_pkg.sv
package mac_rx_pkg;

    // ----------------------------------------------------------------------
    // stream beat and tracker types
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic       valid;
        logic       sop;
        logic       eop;
        logic [7:0] data;
    } rx_byte_t;

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_BODY,
        PH_STATUS,
        PH_FCS,
        PH_END
    } frame_phase_t;

    typedef logic [15:0] byte_idx_t;

    // ----------------------------------------------------------------------
    // frame layout
    // ----------------------------------------------------------------------
    localparam logic [7:0] PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0] SFD_BYTE       = 8'hd5;
    localparam logic [7:0] END_BYTE       = 8'hfd;
    localparam int         PREAMBLE_COUNT = 7;

    // body positions of sequence number and length, high byte first
    localparam int SEQ_HI_IDX   = 4;
    localparam int SEQ_LO_IDX   = 5;
    localparam int LEN_HI_IDX   = 6;
    localparam int LEN_LO_IDX   = 7;
    localparam int MIN_BODY_LEN = 8;

    // trailer field sizes
    localparam int STATUS_LEN = 2;
    localparam int FCS_LEN    = 4;

    // ----------------------------------------------------------------------
    // crc32, reflected form
    // ----------------------------------------------------------------------
    localparam logic [31:0] CRC_INIT = 32'hffff_ffff;
    localparam logic [31:0] CRC_POLY = 32'hedb8_8320;

    function automatic logic [31:0] crc32_step(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h00_0000, data};
        // lsb first, one bit per pass
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

//--- source/rx_preamble_align.sv
`timescale 1ns/100ps

module rx_preamble_align (
    input  logic                 clk_125m,
    input  logic                 rst_125m,
    input  mac_rx_pkg::rx_byte_t pcs_in,
    output mac_rx_pkg::rx_byte_t beat_d1,
    output logic                 body_start
);
    import mac_rx_pkg::*;

    logic       valid_q;
    logic       sop_q;
    logic       eop_q;
    logic [7:0] data_q;
    logic [2:0] pre_cnt;
    logic       pre_full;
    logic       is_pre;

    // ----------------------------------------------------------------------
    // input register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            valid_q <= 1'b0;
            sop_q   <= 1'b0;
            eop_q   <= 1'b0;
        end else begin
            valid_q <= pcs_in.valid;
            sop_q   <= pcs_in.sop;
            eop_q   <= pcs_in.eop;
        end
    end

    always_ff @(posedge clk_125m) begin
        data_q <= pcs_in.data;
    end

    assign beat_d1 = '{valid: valid_q, sop: sop_q, eop: eop_q, data: data_q};

    // ----------------------------------------------------------------------
    // preamble count
    // ----------------------------------------------------------------------
    assign is_pre     = (beat_d1.data == PREAMBLE_BYTE);
    assign pre_full   = (pre_cnt == 3'(PREAMBLE_COUNT));
    assign body_start = beat_d1.valid && !beat_d1.sop && pre_full &&
                        (beat_d1.data == SFD_BYTE);

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            pre_cnt <= 3'd0;
        end else if (beat_d1.valid) begin
            if (beat_d1.sop) begin
                pre_cnt <= is_pre ? 3'd1 : 3'd0;
            end else if (is_pre && pre_cnt != 3'd0 && !pre_full) begin
                pre_cnt <= pre_cnt + 3'd1;
            end else begin
                // delimiter, foreign byte or an eighth 0x55
                pre_cnt <= 3'd0;
            end
        end
    end

endmodule

//--- source/rx_frame_tracker.sv
`timescale 1ns/100ps

module rx_frame_tracker (
    input  logic                     clk_125m,
    input  logic                     rst_125m,
    input  mac_rx_pkg::rx_byte_t     beat_d1,
    input  logic                     body_start,
    output mac_rx_pkg::frame_phase_t phase,
    output mac_rx_pkg::byte_idx_t    idx,
    output logic                     beat_take,
    output logic                     frame_close,
    output logic                     len_err
);
    import mac_rx_pkg::*;

    logic        in_frame;
    logic        lost_eop;
    logic        good_end;
    logic        end_byte_bad;
    logic        len_short;
    logic        body_last;
    logic [15:0] len_q;
    logic [15:0] cur_len;

    // ----------------------------------------------------------------------
    // beat classification
    // ----------------------------------------------------------------------
    assign in_frame  = (phase != PH_IDLE);

    // an sop inside the frame belongs to the next one
    assign beat_take = beat_d1.valid && in_frame && !beat_d1.sop;

    // end byte already passed without eop
    assign lost_eop  = beat_take && (phase == PH_END) && (idx != '0);

    assign frame_close = beat_d1.valid && in_frame &&
                         (beat_d1.sop || beat_d1.eop || lost_eop);

    assign good_end     = beat_take && (phase == PH_END) && (idx == '0) && beat_d1.eop;
    assign end_byte_bad = beat_take && (phase == PH_END) && (idx == '0) &&
                          (beat_d1.data != END_BYTE);

    // ----------------------------------------------------------------------
    // length field
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_125m) begin
        if (beat_take && phase == PH_BODY) begin
            if (idx == byte_idx_t'(LEN_HI_IDX)) begin
                len_q[15:8] <= beat_d1.data;
            end
            if (idx == byte_idx_t'(LEN_LO_IDX)) begin
                len_q[7:0] <= beat_d1.data;
            end
        end
    end

    // low byte bypass so a length of 8 ends on this very beat
    assign cur_len = (idx == byte_idx_t'(LEN_LO_IDX)) ? {len_q[15:8], beat_d1.data} : len_q;

    assign len_short = beat_take && (phase == PH_BODY) &&
                       (idx == byte_idx_t'(LEN_LO_IDX)) &&
                       (cur_len < 16'(MIN_BODY_LEN));

    assign body_last = (idx >= byte_idx_t'(LEN_LO_IDX)) &&
                       (({1'b0, idx} + 17'd1) >= {1'b0, cur_len});

    // ----------------------------------------------------------------------
    // phase walk
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            phase   <= PH_IDLE;
            idx     <= '0;
            len_err <= 1'b0;
        end else if (body_start) begin
            phase   <= PH_BODY;
            idx     <= '0;
            len_err <= 1'b0;
        end else if (frame_close) begin
            phase   <= PH_IDLE;
            idx     <= '0;
            len_err <= len_err || !good_end || end_byte_bad;
        end else if (beat_take) begin
            len_err <= len_err || len_short || end_byte_bad;
            case (phase)
                PH_BODY: begin
                    if (body_last) begin
                        phase <= PH_STATUS;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
                PH_STATUS: begin
                    if (idx == byte_idx_t'(STATUS_LEN - 1)) begin
                        phase <= PH_FCS;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
                PH_FCS: begin
                    if (idx == byte_idx_t'(FCS_LEN - 1)) begin
                        phase <= PH_END;
                        idx   <= '0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
                // end byte seen without eop, next beat closes
                PH_END:  idx <= 16'd1;
                default: idx <= '0;
            endcase
        end
    end

endmodule

//--- source/rx_seq_check.sv
`timescale 1ns/100ps

module rx_seq_check #(
    parameter int SEQ_CHECK_EN = 1
) (
    input  logic                     clk_125m,
    input  logic                     rst_125m,
    input  mac_rx_pkg::rx_byte_t     beat_d1,
    input  mac_rx_pkg::frame_phase_t phase,
    input  mac_rx_pkg::byte_idx_t    idx,
    input  logic                     beat_take,
    output logic                     seq_err
);
    import mac_rx_pkg::*;

    logic        body_beat;
    logic [7:0]  seq_hi_q;
    logic [15:0] seq_prev_q;
    logic [15:0] seq_now;

    assign body_beat = beat_take && (phase == PH_BODY);
    assign seq_now   = {seq_hi_q, beat_d1.data};

    always_ff @(posedge clk_125m) begin
        if (body_beat && idx == byte_idx_t'(SEQ_HI_IDX)) begin
            seq_hi_q <= beat_d1.data;
        end
    end

    // previous number follows every frame that reaches the low byte
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            seq_prev_q <= 16'h0000;
            seq_err    <= 1'b0;
        end else if (body_beat && idx == '0) begin
            seq_err <= 1'b0;
        end else if (body_beat && idx == byte_idx_t'(SEQ_LO_IDX)) begin
            seq_prev_q <= seq_now;
            seq_err    <= (SEQ_CHECK_EN != 0) && (seq_now != seq_prev_q + 16'd1);
        end
    end

endmodule

//--- source/rx_fcs_check.sv
`timescale 1ns/100ps

module rx_fcs_check (
    input  logic                     clk_125m,
    input  logic                     rst_125m,
    input  mac_rx_pkg::rx_byte_t     beat_d1,
    input  mac_rx_pkg::frame_phase_t phase,
    input  mac_rx_pkg::byte_idx_t    idx,
    input  logic                     beat_take,
    input  logic                     frame_close,
    output logic                     crc_err
);
    import mac_rx_pkg::*;

    logic        body_first;
    logic        crc_beat;
    logic        fcs_beat;
    logic        fcs_last;
    logic [31:0] crc_q;
    logic [23:0] fcs_q;
    logic [31:0] fcs_rx;

    // ----------------------------------------------------------------------
    // covered bytes and fcs field
    // ----------------------------------------------------------------------
    assign body_first = beat_take && (phase == PH_BODY) && (idx == '0);
    assign crc_beat   = beat_take && (phase == PH_BODY || phase == PH_STATUS);
    assign fcs_beat   = beat_take && (phase == PH_FCS);
    assign fcs_last   = fcs_beat && (idx == byte_idx_t'(FCS_LEN - 1));

    // full field including the byte on the bus, msb first
    assign fcs_rx = {fcs_q, beat_d1.data};

    always_ff @(posedge clk_125m) begin
        if (body_first) begin
            crc_q <= crc32_step(CRC_INIT, beat_d1.data);
        end else if (crc_beat) begin
            crc_q <= crc32_step(crc_q, beat_d1.data);
        end
        if (fcs_beat) begin
            fcs_q <= {fcs_q[15:0], beat_d1.data};
        end
    end

    // ----------------------------------------------------------------------
    // compare
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            crc_err <= 1'b0;
        end else begin
            if (body_first) begin
                crc_err <= 1'b0;
            end
            if (fcs_last) begin
                crc_err <= (fcs_rx != ~crc_q);
            end
            // closed before the fcs was complete
            if (frame_close && phase != PH_END && !fcs_last) begin
                crc_err <= 1'b1;
            end
        end
    end

endmodule

//--- source/rx_status_append.sv
`timescale 1ns/100ps

module rx_status_append (
    input  logic                     clk_125m,
    input  logic                     rst_125m,
    input  logic                     cfg_err,
    input  mac_rx_pkg::rx_byte_t     beat_d1,
    input  mac_rx_pkg::frame_phase_t phase,
    input  mac_rx_pkg::byte_idx_t    idx,
    input  logic                     beat_take,
    input  logic                     frame_close,
    input  logic                     len_err,
    input  logic                     seq_err,
    input  logic                     crc_err,
    output mac_rx_pkg::rx_byte_t     rx_out
);
    import mac_rx_pkg::*;

    logic       cfg_meta_q;
    logic       cfg_sync_q;
    logic       close_d1_q;
    logic       close_d2_q;
    logic [7:0] stat_hi_q;
    logic [3:0] stat_lo_q;
    logic       fwd;
    logic       out_valid_q;
    logic       out_sop_q;
    logic       out_eop_q;
    logic [7:0] out_data_q;

    // ----------------------------------------------------------------------
    // cfg_err sync and close delay line
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            cfg_meta_q <= 1'b0;
            cfg_sync_q <= 1'b0;
            close_d1_q <= 1'b0;
            close_d2_q <= 1'b0;
        end else begin
            cfg_meta_q <= cfg_err;
            cfg_sync_q <= cfg_meta_q;
            close_d1_q <= frame_close;
            close_d2_q <= close_d1_q;
        end
    end

    // link status word, low nibble is all that goes out
    always_ff @(posedge clk_125m) begin
        if (beat_take && phase == PH_STATUS) begin
            if (idx == '0) begin
                stat_hi_q <= beat_d1.data;
            end else begin
                stat_lo_q <= beat_d1.data[3:0];
            end
        end
    end

    // ----------------------------------------------------------------------
    // output stream
    // ----------------------------------------------------------------------
    assign fwd = beat_take && (phase == PH_BODY);

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            out_valid_q <= 1'b0;
            out_sop_q   <= 1'b0;
            out_eop_q   <= 1'b0;
        end else begin
            out_valid_q <= fwd || close_d1_q || close_d2_q;
            out_sop_q   <= fwd && (idx == '0);
            out_eop_q   <= close_d2_q;
        end
    end

    always_ff @(posedge clk_125m) begin
        if (close_d1_q) begin
            out_data_q <= stat_hi_q;
        end else if (close_d2_q) begin
            out_data_q <= {cfg_sync_q, len_err, seq_err, crc_err, stat_lo_q};
        end else begin
            out_data_q <= beat_d1.data;
        end
    end

    assign rx_out = '{valid: out_valid_q, sop: out_sop_q, eop: out_eop_q, data: out_data_q};

endmodule

//--- source/mac_rx.sv
`timescale 1ns/100ps

module mac_rx #(
    parameter int SEQ_CHECK_EN = 1
) (
    input  logic                 clk_125m,
    input  logic                 rst_125m,
    input  logic                 cfg_err,
    input  mac_rx_pkg::rx_byte_t pcs_in,
    output mac_rx_pkg::rx_byte_t rx_out
);
    import mac_rx_pkg::*;

    rx_byte_t     beat_d1;
    logic         body_start;
    frame_phase_t phase;
    byte_idx_t    idx;
    logic         beat_take;
    logic         frame_close;
    logic         len_err;
    logic         seq_err;
    logic         crc_err;

    // ----------------------------------------------------------------------
    // front end and frame position
    // ----------------------------------------------------------------------
    rx_preamble_align u_align (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .pcs_in     (pcs_in),
        .beat_d1    (beat_d1),
        .body_start (body_start)
    );

    rx_frame_tracker u_tracker (
        .clk_125m    (clk_125m),
        .rst_125m    (rst_125m),
        .beat_d1     (beat_d1),
        .body_start  (body_start),
        .phase       (phase),
        .idx         (idx),
        .beat_take   (beat_take),
        .frame_close (frame_close),
        .len_err     (len_err)
    );

    // ----------------------------------------------------------------------
    // checks and output
    // ----------------------------------------------------------------------
    rx_seq_check #(
        .SEQ_CHECK_EN (SEQ_CHECK_EN)
    ) u_seq (
        .clk_125m  (clk_125m),
        .rst_125m  (rst_125m),
        .beat_d1   (beat_d1),
        .phase     (phase),
        .idx       (idx),
        .beat_take (beat_take),
        .seq_err   (seq_err)
    );

    rx_fcs_check u_fcs (
        .clk_125m    (clk_125m),
        .rst_125m    (rst_125m),
        .beat_d1     (beat_d1),
        .phase       (phase),
        .idx         (idx),
        .beat_take   (beat_take),
        .frame_close (frame_close),
        .crc_err     (crc_err)
    );

    rx_status_append u_status (
        .clk_125m    (clk_125m),
        .rst_125m    (rst_125m),
        .cfg_err     (cfg_err),
        .beat_d1     (beat_d1),
        .phase       (phase),
        .idx         (idx),
        .beat_take   (beat_take),
        .frame_close (frame_close),
        .len_err     (len_err),
        .seq_err     (seq_err),
        .crc_err     (crc_err),
        .rx_out      (rx_out)
    );

endmodule

//--- tests/mac_rx_assertions.sv
`timescale 1ns/100ps

module mac_rx_assertions (
    input logic                 clk_125m,
    input logic                 rst_125m,
    input mac_rx_pkg::rx_byte_t rx_out,
    input logic                 frame_close
);

    // output strobes quiet while reset is held
    a_reset_quiet: assert property (
        @(posedge clk_125m) !rst_125m |-> !(rx_out.valid || rx_out.sop || rx_out.eop)
    ) else $error("rx_out strobe high while reset is held");

    // frame marks only on valid beats
    a_marks_need_valid: assert property (
        @(posedge clk_125m) disable iff (!rst_125m)
        (rx_out.sop || rx_out.eop) |-> rx_out.valid
    ) else $error("rx_out sop or eop without valid");

    // second status byte closes the output frame 3 cycles after the close pulse
    a_status_after_close: assert property (
        @(posedge clk_125m) disable iff (!rst_125m)
        frame_close |-> ##3 (rx_out.valid && rx_out.eop)
    ) else $error("status byte two missing 3 cycles after frame close");

endmodule

bind mac_rx mac_rx_assertions u_assertions (
    .clk_125m    (clk_125m),
    .rst_125m    (rst_125m),
    .rx_out      (rx_out),
    .frame_close (frame_close)
);

//--- tests/mac_rx_tb.sv
`timescale 1ns/100ps

module mac_rx_tb;
    import mac_rx_pkg::*;

    localparam int CLK_PERIOD       = 8;
    localparam int FRAME_COUNT      = 32;
    localparam int MAX_BODY_LEN     = 40;
    // each beat may take three gap cycles, plus idle after the frame
    localparam int MAX_FRAME_CYCLES = 4 * (PREAMBLE_COUNT + MAX_BODY_LEN + 10) + 13;
    localparam int WATCHDOG_NS      = (FRAME_COUNT * MAX_FRAME_CYCLES + 200) * CLK_PERIOD;

    // frame kinds
    localparam int K_CLEAN     = 0;
    localparam int K_BAD_FCS   = 1;
    localparam int K_BAD_BODY  = 2;
    localparam int K_EARLY_EOP = 3;
    localparam int K_NO_EOP    = 4;
    localparam int K_BAD_END   = 5;
    localparam int K_SHORT_PRE = 6;
    localparam int K_BAD_PRE   = 7;

    typedef struct packed {
        logic [31:0] cyc;
        logic        sop;
        logic        eop;
        logic [7:0]  data;
    } exp_beat_t;

    logic        clk_125m;
    logic        rst_125m;
    logic        cfg_err;
    rx_byte_t    pcs_in;
    rx_byte_t    rx_out;

    exp_beat_t   exp_q [$];
    integer      seed;
    int          cyc = 0;
    int          errors;
    int          checks;
    int          err_mark;
    int          tests_run;
    logic [15:0] model_prev;

    mac_rx #(
        .SEQ_CHECK_EN (1)
    ) DUT (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .cfg_err  (cfg_err),
        .pcs_in   (pcs_in),
        .rx_out   (rx_out)
    );

    initial begin
        clk_125m = 1'b0;
        forever #(CLK_PERIOD / 2) clk_125m = ~clk_125m;
    end

    always @(posedge clk_125m) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%h, expected 0x%h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic compare_output();
        exp_beat_t e;
        if (rx_out.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output beat 0x%h at cycle %0d when none was expected",
                         rx_out.data, cyc);
            end else begin
                e = exp_q.pop_front();
                check_value("rx_out arrival cycle", cyc, e.cyc);
                check_value("rx_out.sop", rx_out.sop, e.sop);
                check_value("rx_out.eop", rx_out.eop, e.eop);
                check_value("rx_out.data", rx_out.data, e.data);
            end
        end else if (exp_q.size() != 0 && exp_q[0].cyc <= cyc) begin
            errors++;
            $display("expected output beat 0x%h did not appear at cycle %0d",
                     exp_q[0].data, exp_q[0].cyc);
            e = exp_q.pop_front();
        end
    endtask

    task automatic expect_beat(input int at, input logic sop, input logic eop,
                               input logic [7:0] data);
        exp_q.push_back(exp_beat_t'{cyc: at, sop: sop, eop: eop, data: data});
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic drive_beat(input rx_byte_t b);
        @(negedge clk_125m);
        compare_output();
        pcs_in = b;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            drive_beat(rx_byte_t'{valid: 1'b0, sop: 1'b0, eop: 1'b0, data: 8'($random(seed))});
        end
    endtask

    // random valid-low gap ahead of some beats
    task automatic send_beat(input logic sop, input logic eop, input logic [7:0] data);
        if (($random(seed) & 3) == 0) begin
            idle(1 + $unsigned($random(seed)) % 3);
        end
        drive_beat(rx_byte_t'{valid: 1'b1, sop: sop, eop: eop, data: data});
    endtask

    // reflected crc32, one data bit per pass
    function automatic logic [31:0] crc_ref(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ data[i];
            r  = {1'b0, r[31:1]} ^ (fb ? 32'hedb8_8320 : 32'h0000_0000);
        end
        return r;
    endfunction

    task automatic send_frame(input int kind, input logic [15:0] seq);
        logic [7:0]  body [0:MAX_BODY_LEN-1];
        logic [7:0]  tr [0:6];
        logic [15:0] len;
        logic [15:0] stat;
        logic [31:0] crc;
        logic [7:0]  mask;
        logic        pre_ok;
        logic        l_err;
        logic        s_err;
        logic        c_err;
        int          n_pre;
        int          pre_pos;
        int          bad_pos;
        int          last;

        len     = 16'(MIN_BODY_LEN + $unsigned($random(seed)) % (MAX_BODY_LEN - 7));
        stat    = 16'($random(seed));
        mask    = 8'h01 << ($unsigned($random(seed)) % 8);
        pre_pos = $unsigned($random(seed)) % PREAMBLE_COUNT;
        bad_pos = $unsigned($random(seed)) % 4;
        for (int i = 0; i < MAX_BODY_LEN; i++) begin
            body[i] = 8'($random(seed));
        end
        body[SEQ_HI_IDX] = seq[15:8];
        body[SEQ_LO_IDX] = seq[7:0];
        body[LEN_HI_IDX] = len[15:8];
        body[LEN_LO_IDX] = len[7:0];

        // fcs over body and link status, sent msb first
        crc = CRC_INIT;
        for (int i = 0; i < len; i++) begin
            crc = crc_ref(crc, body[i]);
        end
        crc   = crc_ref(crc, stat[15:8]);
        crc   = ~crc_ref(crc, stat[7:0]);
        tr[0] = stat[15:8];
        tr[1] = stat[7:0];
        tr[2] = crc[31:24];
        tr[3] = crc[23:16];
        tr[4] = crc[15:8];
        tr[5] = crc[7:0];
        tr[6] = END_BYTE;

        c_err = 1'b0;
        case (kind)
            K_BAD_FCS: begin
                tr[2 + bad_pos] = tr[2 + bad_pos] ^ mask;
                c_err = 1'b1;
            end
            K_BAD_BODY: begin
                body[bad_pos] = body[bad_pos] ^ mask;
                c_err = 1'b1;
            end
            K_BAD_END: tr[6] = END_BYTE ^ mask;
            default: ;
        endcase

        // early eop lands on one of the fcs bytes
        last = (kind == K_EARLY_EOP) ? 2 + bad_pos : 6;
        if (last < 5) begin
            c_err = 1'b1;
        end
        l_err  = (kind == K_EARLY_EOP) || (kind == K_NO_EOP) || (kind == K_BAD_END);
        pre_ok = (kind != K_SHORT_PRE) && (kind != K_BAD_PRE);
        n_pre  = (kind == K_SHORT_PRE) ? PREAMBLE_COUNT - 1 : PREAMBLE_COUNT;

        for (int i = 0; i < n_pre; i++) begin
            send_beat(i == 0, 1'b0,
                      (kind == K_BAD_PRE && i == pre_pos) ? PREAMBLE_BYTE ^ mask : PREAMBLE_BYTE);
        end
        send_beat(1'b0, 1'b0, SFD_BYTE);
        for (int i = 0; i < len; i++) begin
            send_beat(1'b0, 1'b0, body[i]);
            if (pre_ok) begin
                expect_beat(cyc + 2, i == 0, 1'b0, body[i]);
            end
        end
        for (int i = 0; i <= last; i++) begin
            send_beat(1'b0, (i == last) && (kind != K_NO_EOP), tr[i]);
        end
        // lost eop, the next valid beat closes the frame
        if (kind == K_NO_EOP) begin
            send_beat(1'b0, 1'b0, 8'h00);
        end

        if (pre_ok) begin
            s_err      = (seq != model_prev + 16'd1);
            model_prev = seq;
            expect_beat(cyc + 3, 1'b0, 1'b0, stat[15:8]);
            expect_beat(cyc + 4, 1'b0, 1'b1, {cfg_err, l_err, s_err, c_err, stat[3:0]});
        end
        idle(2 + $unsigned($random(seed)) % 4);
    endtask

    task automatic end_test(input string name);
        idle(8);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected output beats never appeared", exp_q.size());
            exp_q.delete();
        end
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    // ----------------------------------------------------------------------
    // watchdog and test sequence
    // ----------------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed       = 32'h503c_a67e;
        pcs_in     = '0;
        cfg_err    = 1'b0;
        rst_125m   = 1'b0;
        model_prev = 16'h0000;
        errors     = 0;
        checks     = 0;
        err_mark   = 0;
        tests_run  = 0;
        repeat (5) @(posedge clk_125m);
        @(negedge clk_125m);
        rst_125m = 1'b1;
        idle(4);

        for (int i = 0; i < 8; i++) begin
            send_frame(K_CLEAN, model_prev + 16'd1);
        end
        end_test("clean frames");

        for (int i = 0; i < 6; i++) begin
            send_frame((i % 2 == 0) ? K_BAD_FCS : K_BAD_BODY, model_prev + 16'd1);
        end
        end_test("corrupted fcs or body");

        send_frame(K_CLEAN, model_prev + 16'd1);
        send_frame(K_CLEAN, model_prev + 16'd2);
        send_frame(K_CLEAN, model_prev + 16'd1);
        send_frame(K_CLEAN, model_prev + 16'd1);
        end_test("skipped sequence number");

        for (int i = 0; i < 6; i++) begin
            send_frame(K_EARLY_EOP + i % 3, model_prev + 16'd1);
        end
        end_test("early eop, lost eop, wrong end byte");

        for (int i = 0; i < 4; i++) begin
            send_frame(K_SHORT_PRE + i % 2, model_prev + 16'd1);
        end
        send_frame(K_CLEAN, model_prev + 16'd1);
        end_test("broken preamble");

        cfg_err = 1'b1;
        for (int i = 0; i < 3; i++) begin
            send_frame(K_CLEAN, model_prev + 16'd1);
        end
        end_test("cfg_err and link status");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
source/mac_rx_pkg.sv
source/rx_preamble_align.sv
source/rx_frame_tracker.sv
source/rx_seq_check.sv
source/rx_fcs_check.sv
source/rx_status_append.sv
source/mac_rx.sv
tests/mac_rx_assertions.sv
tests/mac_rx_tb.sv

//--- Bender.yml
package:
  name: mac_rx

sources:
  - source/mac_rx_pkg.sv
  - source/rx_preamble_align.sv
  - source/rx_frame_tracker.sv
  - source/rx_seq_check.sv
  - source/rx_fcs_check.sv
  - source/rx_status_append.sv
  - source/mac_rx.sv
  - target: test
    files:
      - tests/mac_rx_assertions.sv
      - tests/mac_rx_tb.sv
